// ==== hw/axi_sram_cfg.svh ====
// AXI SRAM configuration: bus widths and SRAM depth
`ifndef AXI_SRAM_CFG_SVH
`define AXI_SRAM_CFG_SVH

// Data bus width in bits
`define AXI_SRAM_DATA_W 64

// Byte address width
`define AXI_SRAM_ADDR_W 32

// Transaction ID width
`define AXI_SRAM_ID_W 4

// Number of SRAM words, 2048 bytes at 64 bits
`define AXI_SRAM_DEPTH 256

`endif

// ==== hw/axi_sram_pkg.sv ====
// AXI SRAM package: shared ID, response, data, strobe and address types
`default_nettype none

`include "axi_sram_cfg.svh"

package axi_sram_pkg;

  typedef logic [`AXI_SRAM_ID_W-1:0] axi_id_t;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } axi_resp_t;

  typedef logic [`AXI_SRAM_DATA_W-1:0] sram_word_t;

  // One enable bit per data byte
  typedef logic [`AXI_SRAM_DATA_W/8-1:0] sram_strb_t;

  typedef logic [`AXI_SRAM_ADDR_W-1:0] axi_addr_t;

endpackage

`default_nettype wire

// ==== hw/sram_req_if.sv ====
// Request and response links between the AXI SRAM pipeline stages
`timescale 1ns/100ps
`default_nettype none

interface sram_req_if;
  logic                     valid;
  logic                     ready;
  logic                     we;
  axi_sram_pkg::axi_addr_t  addr;
  axi_sram_pkg::sram_word_t wdata;
  axi_sram_pkg::sram_strb_t wstrb;
  axi_sram_pkg::axi_id_t    id;

  modport source (output valid, we, addr, wdata, wstrb, id, input ready);
  modport sink   (input valid, we, addr, wdata, wstrb, id, output ready);
endinterface

interface sram_rsp_if;
  logic                     valid;
  logic                     ready;
  logic                     we;
  axi_sram_pkg::axi_resp_t  resp;
  axi_sram_pkg::axi_id_t    id;
  axi_sram_pkg::sram_word_t rdata;

  modport source (output valid, we, resp, id, rdata, input ready);
  modport sink   (input valid, we, resp, id, rdata, output ready);
endinterface

`default_nettype wire

// ==== hw/axi_sram_req_stage.sv ====
// AXI SRAM request stage: accepts AW, W and AR and issues one request at a time
`timescale 1ns/100ps
`default_nettype none

module axi_sram_req_stage (
  input  wire                            i_aclk,
  input  wire                            i_rst_n,
  input  wire axi_sram_pkg::axi_id_t     i_awid,
  input  wire axi_sram_pkg::axi_addr_t   i_awaddr,
  input  wire [7:0]                      i_awlen,
  input  wire                            i_awvalid,
  output logic                           o_awready,
  input  wire axi_sram_pkg::sram_word_t  i_wdata,
  input  wire axi_sram_pkg::sram_strb_t  i_wstrb,
  input  wire                            i_wlast,
  input  wire                            i_wvalid,
  output logic                           o_wready,
  input  wire axi_sram_pkg::axi_id_t     i_arid,
  input  wire axi_sram_pkg::axi_addr_t   i_araddr,
  input  wire [7:0]                      i_arlen,
  input  wire                            i_arvalid,
  output logic                           o_arready,
  sram_req_if.source                     m_req
);

  logic                     aw_full, w_full, ar_full;
  axi_sram_pkg::axi_id_t    aw_id_q, ar_id_q;
  axi_sram_pkg::axi_addr_t  aw_addr_q, ar_addr_q;
  axi_sram_pkg::sram_word_t w_data_q;
  axi_sram_pkg::sram_strb_t w_strb_q;
  logic                     aw_fire, w_fire, ar_fire;
  logic                     wr_elig, rd_elig;
  logic                     load, pick_wr, pick_rd;
  logic                     last_wr;
  logic                     req_valid;

  // ------------------------------------------------------------------
  // Channel holding registers
  // ------------------------------------------------------------------
  assign o_awready = !aw_full;
  assign o_wready  = !w_full;
  assign o_arready = !ar_full;

  assign aw_fire = i_awvalid && !aw_full;
  assign w_fire  = i_wvalid && !w_full;
  assign ar_fire = i_arvalid && !ar_full;

  // A channel counts as present when held or offered right now
  assign wr_elig = (aw_full || i_awvalid) && (w_full || i_wvalid);
  assign rd_elig = ar_full || i_arvalid;

  // ------------------------------------------------------------------
  // Read/write alternation
  // ------------------------------------------------------------------
  assign load    = !req_valid || m_req.ready;
  assign pick_wr = load && wr_elig && (!rd_elig || !last_wr);
  assign pick_rd = load && rd_elig && !pick_wr;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      aw_full   <= 1'b0;
      w_full    <= 1'b0;
      ar_full   <= 1'b0;
      req_valid <= 1'b0;
      last_wr   <= 1'b0;
    end else begin
      aw_full <= (aw_full || aw_fire) && !pick_wr;
      w_full  <= (w_full || w_fire) && !pick_wr;
      ar_full <= (ar_full || ar_fire) && !pick_rd;
      if (load) begin
        req_valid <= pick_wr || pick_rd;
      end
      if (pick_wr || pick_rd) begin
        last_wr <= pick_wr;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      aw_id_q   <= i_awid;
      aw_addr_q <= i_awaddr;
    end
    if (w_fire) begin
      w_data_q <= i_wdata;
      w_strb_q <= i_wstrb;
    end
    if (ar_fire) begin
      ar_id_q   <= i_arid;
      ar_addr_q <= i_araddr;
    end
    // Output request register
    if (pick_wr) begin
      m_req.we    <= 1'b1;
      m_req.id    <= aw_full ? aw_id_q : i_awid;
      m_req.addr  <= aw_full ? aw_addr_q : i_awaddr;
      m_req.wdata <= w_full ? w_data_q : i_wdata;
      m_req.wstrb <= w_full ? w_strb_q : i_wstrb;
    end else if (pick_rd) begin
      m_req.we   <= 1'b0;
      m_req.id   <= ar_full ? ar_id_q : i_arid;
      m_req.addr <= ar_full ? ar_addr_q : i_araddr;
    end
  end

  assign m_req.valid = req_valid;

  // Single-beat transfers only
  a_awlen_zero: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid |-> i_awlen == 8'd0);
  a_arlen_zero: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_arvalid |-> i_arlen == 8'd0);
  a_wlast_set: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_wvalid |-> i_wlast);

endmodule

`default_nettype wire

// ==== hw/axi_sram_mem_stage.sv ====
// AXI SRAM memory stage: byte-strobed SRAM with range check and registered result
`timescale 1ns/100ps
`default_nettype none

`include "axi_sram_cfg.svh"

module axi_sram_mem_stage (
  input  wire        i_aclk,
  input  wire        i_rst_n,
  sram_req_if.sink   s_req,
  sram_rsp_if.source m_rsp
);

  localparam int OFF_W = $clog2(`AXI_SRAM_DATA_W / 8);
  localparam int IDX_W = $clog2(`AXI_SRAM_DEPTH);

  axi_sram_pkg::sram_word_t mem [`AXI_SRAM_DEPTH];
  logic                     req_fire;
  logic                     in_range;
  logic [IDX_W-1:0]         idx;
  logic                     rsp_valid;

  assign req_fire    = s_req.valid && s_req.ready;
  assign s_req.ready = !rsp_valid || m_rsp.ready;

  // Word index, byte offset bits dropped
  assign in_range = (s_req.addr >> OFF_W) < axi_sram_pkg::axi_addr_t'(`AXI_SRAM_DEPTH);
  assign idx      = s_req.addr[IDX_W+OFF_W-1:OFF_W];

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rsp_valid <= 1'b0;
    end else if (s_req.ready) begin
      rsp_valid <= s_req.valid;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (req_fire) begin
      m_rsp.we    <= s_req.we;
      m_rsp.id    <= s_req.id;
      m_rsp.resp  <= in_range ? axi_sram_pkg::OKAY : axi_sram_pkg::SLVERR;
      m_rsp.rdata <= (in_range && !s_req.we) ? mem[idx] : '0;
      if (in_range && s_req.we) begin
        for (int b = 0; b < `AXI_SRAM_DATA_W / 8; b++) begin
          if (s_req.wstrb[b]) begin
            mem[idx][8*b +: 8] <= s_req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign m_rsp.valid = rsp_valid;

  a_rsp_idle_after_rst: assert property (@(posedge i_aclk) !i_rst_n |=> !m_rsp.valid);

endmodule

`default_nettype wire

// ==== hw/axi_sram_rsp_stage.sv ====
// AXI SRAM response stage: holds one result and returns it on B or R
`timescale 1ns/100ps
`default_nettype none

module axi_sram_rsp_stage (
  input  wire                       i_aclk,
  input  wire                       i_rst_n,
  sram_rsp_if.sink                  s_rsp,
  input  wire                       i_bready,
  output axi_sram_pkg::axi_id_t     o_bid,
  output axi_sram_pkg::axi_resp_t   o_bresp,
  output logic                      o_bvalid,
  input  wire                       i_rready,
  output axi_sram_pkg::axi_id_t     o_rid,
  output axi_sram_pkg::sram_word_t  o_rdata,
  output axi_sram_pkg::axi_resp_t   o_rresp,
  output logic                      o_rlast,
  output logic                      o_rvalid
);

  logic                     hold_valid;
  logic                     hold_we;
  axi_sram_pkg::axi_resp_t  hold_resp;
  axi_sram_pkg::axi_id_t    hold_id;
  axi_sram_pkg::sram_word_t hold_rdata;
  logic                     take;

  // ------------------------------------------------------------------
  // Response register
  // ------------------------------------------------------------------
  // Freed by the ready of whichever channel it drives
  assign take        = hold_valid && (hold_we ? i_bready : i_rready);
  assign s_rsp.ready = !hold_valid || take;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      hold_valid <= 1'b0;
    end else if (s_rsp.ready) begin
      hold_valid <= s_rsp.valid;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (s_rsp.valid && s_rsp.ready) begin
      hold_we    <= s_rsp.we;
      hold_resp  <= s_rsp.resp;
      hold_id    <= s_rsp.id;
      hold_rdata <= s_rsp.rdata;
    end
  end

  // ------------------------------------------------------------------
  // B and R channels
  // ------------------------------------------------------------------
  assign o_bvalid = hold_valid && hold_we;
  assign o_bid    = hold_id;
  assign o_bresp  = hold_resp;

  assign o_rvalid = hold_valid && !hold_we;
  assign o_rid    = hold_id;
  assign o_rresp  = hold_resp;
  assign o_rdata  = hold_rdata;
  // Every read is one beat
  assign o_rlast  = 1'b1;

  a_one_channel: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(o_bvalid && o_rvalid));

endmodule

`default_nettype wire

// ==== hw/axi_sram_top.sv ====
// AXI SRAM top level: AXI4 slave ports over the request, memory and response stages
`timescale 1ns/100ps
`default_nettype none

`include "axi_sram_cfg.svh"

module axi_sram_top (
  input  wire                          i_aclk,
  input  wire                          i_rst_n,
  // Write address
  input  wire  [`AXI_SRAM_ID_W-1:0]    i_awid,
  input  wire  [`AXI_SRAM_ADDR_W-1:0]  i_awaddr,
  input  wire  [7:0]                   i_awlen,
  input  wire  [1:0]                   i_awsize,
  input  wire  [1:0]                   i_awburst,
  input  wire  [1:0]                   i_awlock,
  input  wire  [3:0]                   i_awcache,
  input  wire  [2:0]                   i_awprot,
  input  wire                          i_awvalid,
  output logic                         o_awready,
  // Write data
  input  wire  [`AXI_SRAM_ID_W-1:0]    i_wid,
  input  wire  [`AXI_SRAM_DATA_W-1:0]  i_wdata,
  input  wire  [`AXI_SRAM_DATA_W/8-1:0] i_wstrb,
  input  wire                          i_wlast,
  input  wire                          i_wvalid,
  output logic                         o_wready,
  // Write response
  output logic [`AXI_SRAM_ID_W-1:0]    o_bid,
  output logic [1:0]                   o_bresp,
  output logic                         o_bvalid,
  input  wire                          i_bready,
  // Read address
  input  wire  [`AXI_SRAM_ID_W-1:0]    i_arid,
  input  wire  [`AXI_SRAM_ADDR_W-1:0]  i_araddr,
  input  wire  [7:0]                   i_arlen,
  input  wire  [1:0]                   i_arsize,
  input  wire  [1:0]                   i_arburst,
  input  wire  [1:0]                   i_arlock,
  input  wire  [3:0]                   i_arcache,
  input  wire  [2:0]                   i_arprot,
  input  wire                          i_arvalid,
  output logic                         o_arready,
  // Read data
  output logic [`AXI_SRAM_ID_W-1:0]    o_rid,
  output logic [`AXI_SRAM_DATA_W-1:0]  o_rdata,
  output logic [1:0]                   o_rresp,
  output logic                         o_rlast,
  output logic                         o_rvalid,
  input  wire                          i_rready
);

  // Size, burst, lock, cache, prot and WID carry nothing for single beats

  sram_req_if req_if ();
  sram_rsp_if rsp_if ();

  axi_sram_req_stage u_req (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awid    (i_awid),
    .i_awaddr  (i_awaddr),
    .i_awlen   (i_awlen),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wlast   (i_wlast),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_arid    (i_arid),
    .i_araddr  (i_araddr),
    .i_arlen   (i_arlen),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .m_req     (req_if.source)
  );

  axi_sram_mem_stage u_mem (
    .i_aclk  (i_aclk),
    .i_rst_n (i_rst_n),
    .s_req   (req_if.sink),
    .m_rsp   (rsp_if.source)
  );

  axi_sram_rsp_stage u_rsp (
    .i_aclk   (i_aclk),
    .i_rst_n  (i_rst_n),
    .s_rsp    (rsp_if.sink),
    .i_bready (i_bready),
    .o_bid    (o_bid),
    .o_bresp  (o_bresp),
    .o_bvalid (o_bvalid),
    .i_rready (i_rready),
    .o_rid    (o_rid),
    .o_rdata  (o_rdata),
    .o_rresp  (o_rresp),
    .o_rlast  (o_rlast),
    .o_rvalid (o_rvalid)
  );

endmodule

`default_nettype wire

// ==== sim/axi_sram_tb.sv ====
// Testbench for the AXI SRAM slave: random AXI traffic checked against a memory model
`timescale 1ns/100ps
`default_nettype none

`include "axi_sram_cfg.svh"

module axi_sram_tb;

  localparam int TIMEOUT = 200;
  localparam int STRB_W  = `AXI_SRAM_DATA_W / 8;
  localparam axi_sram_pkg::axi_addr_t ADDR_LIMIT = `AXI_SRAM_DEPTH * STRB_W;

  logic                          i_aclk, i_rst_n;
  logic [`AXI_SRAM_ID_W-1:0]     i_awid, i_wid, i_arid, o_bid, o_rid;
  logic [`AXI_SRAM_ADDR_W-1:0]   i_awaddr, i_araddr;
  logic [7:0]                    i_awlen, i_arlen;
  logic [1:0]                    i_awsize, i_awburst, i_awlock;
  logic [1:0]                    i_arsize, i_arburst, i_arlock;
  logic [3:0]                    i_awcache, i_arcache;
  logic [2:0]                    i_awprot, i_arprot;
  logic                          i_awvalid, o_awready, i_wlast, i_wvalid, o_wready;
  logic [`AXI_SRAM_DATA_W-1:0]   i_wdata, o_rdata;
  logic [`AXI_SRAM_DATA_W/8-1:0] i_wstrb;
  logic [1:0]                    o_bresp, o_rresp;
  logic                          o_bvalid, i_bready, i_arvalid, o_arready;
  logic                          o_rlast, o_rvalid, i_rready;

  // Reference model
  axi_sram_pkg::sram_word_t model [`AXI_SRAM_DEPTH];
  axi_sram_pkg::axi_id_t    bq_id[$], rq_id[$];
  axi_sram_pkg::axi_resp_t  bq_resp[$], rq_resp[$];
  axi_sram_pkg::sram_word_t rq_data[$];

  axi_sram_top uut (.*);

  initial begin
    i_aclk = 1'b0;
    forever #50 i_aclk = ~i_aclk;
  end

  // ------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ------------------------------------------------------------------
  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    stop_run();
  endtask

  task automatic check_resp(input string name, input axi_sram_pkg::axi_resp_t exp,
                            input axi_sram_pkg::axi_resp_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_id(input string name, input axi_sram_pkg::axi_id_t exp,
                          input axi_sram_pkg::axi_id_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input axi_sram_pkg::sram_word_t exp,
                            input axi_sram_pkg::sram_word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  // ------------------------------------------------------------------
  // Bus helpers
  // ------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge i_aclk);
    #10;
  endtask

  function automatic int word_idx(input axi_sram_pkg::axi_addr_t addr);
    return int'(addr >> 3);
  endfunction

  // Depth is a power of two, so one set bit lands out of range
  function automatic axi_sram_pkg::axi_addr_t rand_addr();
    if ($urandom_range(7) == 0) begin
      return axi_sram_pkg::axi_addr_t'($urandom) | ADDR_LIMIT;
    end
    return axi_sram_pkg::axi_addr_t'($urandom) % ADDR_LIMIT;
  endfunction

  task automatic do_write(input axi_sram_pkg::axi_id_t id, input axi_sram_pkg::axi_addr_t addr,
                          input axi_sram_pkg::sram_word_t data,
                          input axi_sram_pkg::sram_strb_t strb);
    int  n;
    bit  aw_done, w_done, got;
    i_awid = id;
    i_awaddr = addr;
    i_awvalid = 1'b1;
    i_wdata = data;
    i_wstrb = strb;
    i_wvalid = 1'b1;
    aw_done = 1'b0;
    w_done = 1'b0;
    n = 0;
    while (!(aw_done && w_done)) begin
      if (i_awvalid && o_awready) aw_done = 1'b1;
      if (i_wvalid && o_wready) w_done = 1'b1;
      next_cycle();
      if (aw_done) i_awvalid = 1'b0;
      if (w_done) i_wvalid = 1'b0;
      n = n + 1;
      if (n > TIMEOUT) report_timeout("write address and data handshake");
    end
    bq_id.push_back(id);
    if (addr < ADDR_LIMIT) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) model[word_idx(addr)][8*b +: 8] = data[8*b +: 8];
      end
      bq_resp.push_back(axi_sram_pkg::OKAY);
    end else begin
      bq_resp.push_back(axi_sram_pkg::SLVERR);
    end
    got = 1'b0;
    n = 0;
    while (!got) begin
      i_bready = ($urandom_range(3) != 0);
      if (o_bvalid && i_bready) begin
        check_id("write bid", bq_id.pop_front(), o_bid);
        check_resp("write bresp", bq_resp.pop_front(), axi_sram_pkg::axi_resp_t'(o_bresp));
        got = 1'b1;
      end
      next_cycle();
      n = n + 1;
      if (n > TIMEOUT) report_timeout("write response");
    end
    // Only one write is outstanding, so nothing may follow its response
    if (o_bvalid) begin
      $display("A second write response followed a single write");
      stop_run();
    end
    i_bready = 1'b0;
  endtask

  task automatic do_read(input axi_sram_pkg::axi_id_t id, input axi_sram_pkg::axi_addr_t addr);
    int n;
    bit got;
    i_arid = id;
    i_araddr = addr;
    i_arvalid = 1'b1;
    n = 0;
    while (!o_arready) begin
      next_cycle();
      n = n + 1;
      if (n > TIMEOUT) report_timeout("read address handshake");
    end
    next_cycle();
    i_arvalid = 1'b0;
    rq_id.push_back(id);
    if (addr < ADDR_LIMIT) begin
      rq_resp.push_back(axi_sram_pkg::OKAY);
      rq_data.push_back(model[word_idx(addr)]);
    end else begin
      rq_resp.push_back(axi_sram_pkg::SLVERR);
      rq_data.push_back('0);
    end
    got = 1'b0;
    n = 0;
    while (!got) begin
      i_rready = ($urandom_range(3) != 0);
      if (o_rvalid && i_rready) begin
        check_id("read rid", rq_id.pop_front(), o_rid);
        check_resp("read rresp", rq_resp.pop_front(), axi_sram_pkg::axi_resp_t'(o_rresp));
        check_data("read rdata", rq_data.pop_front(), o_rdata);
        check_bit("read rlast", 1'b1, o_rlast);
        got = 1'b1;
      end
      next_cycle();
      n = n + 1;
      if (n > TIMEOUT) report_timeout("read data beat");
    end
    // Only one read is outstanding, so nothing may follow its beat
    if (o_rvalid) begin
      $display("A second read beat followed a single read");
      stop_run();
    end
    i_rready = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    axi_sram_pkg::axi_addr_t  wa, ra;
    axi_sram_pkg::axi_id_t    wid, rid;
    axi_sram_pkg::sram_word_t wd;
    axi_sram_pkg::sram_strb_t ws;
    void'($urandom(32'h68d0_d80a));
    {i_awid, i_wid, i_arid, i_awaddr, i_araddr} = '0;
    {i_awlen, i_arlen, i_awlock, i_arlock, i_awcache, i_arcache} = '0;
    {i_awprot, i_arprot, i_wdata, i_wstrb} = '0;
    i_awsize = 2'd3;
    i_arsize = 2'd3;
    i_awburst = 2'd1;
    i_arburst = 2'd1;
    i_wlast = 1'b1;
    {i_awvalid, i_wvalid, i_arvalid, i_bready, i_rready} = '0;
    i_rst_n = 1'b0;
    repeat (4) @(posedge i_aclk);
    #10;
    i_rst_n = 1'b1;

    check_bit("reset bvalid", 1'b0, o_bvalid);
    check_bit("reset rvalid", 1'b0, o_rvalid);
    check_bit("reset awready", 1'b1, o_awready);
    check_bit("reset wready", 1'b1, o_wready);
    check_bit("reset arready", 1'b1, o_arready);

    // Fill every word so later reads have known data
    for (int k = 0; k < `AXI_SRAM_DEPTH; k++) begin
      do_write(axi_sram_pkg::axi_id_t'(k), axi_sram_pkg::axi_addr_t'(k * STRB_W),
               {$urandom, $urandom}, '1);
    end

    // Out of range on both channels
    do_write(axi_sram_pkg::axi_id_t'(3), ADDR_LIMIT, {$urandom, $urandom}, '1);
    do_read(axi_sram_pkg::axi_id_t'(5), ADDR_LIMIT + 8);
    do_read(axi_sram_pkg::axi_id_t'(6), 32'hFFFF_FFF8);

    // Concurrent reads and writes with random back-pressure
    for (int i = 0; i < 200; i++) begin
      wa = rand_addr();
      ra = rand_addr();
      while (wa < ADDR_LIMIT && ra < ADDR_LIMIT && word_idx(wa) == word_idx(ra)) begin
        ra = rand_addr();
      end
      wid = axi_sram_pkg::axi_id_t'($urandom);
      rid = axi_sram_pkg::axi_id_t'($urandom);
      wd = {$urandom, $urandom};
      ws = axi_sram_pkg::sram_strb_t'($urandom);
      fork
        do_write(wid, wa, wd, ws);
        do_read(rid, ra);
      join
    end

    // Read back all of memory
    for (int k = 0; k < `AXI_SRAM_DEPTH; k++) begin
      do_read(axi_sram_pkg::axi_id_t'($urandom), axi_sram_pkg::axi_addr_t'(k * STRB_W));
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== axi_sram.f ====
+incdir+hw
hw/axi_sram_pkg.sv
hw/sram_req_if.sv
hw/axi_sram_req_stage.sv
hw/axi_sram_mem_stage.sv
hw/axi_sram_rsp_stage.sv
hw/axi_sram_top.sv
sim/axi_sram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the AXI SRAM testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f axi_sram.f --top-module axi_sram_tb -o axi_sram_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed"
  exit 1
fi

./obj_dir/axi_sram_sim > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "TESTBENCH FAILED" "$SIM_LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
